//--- Bender.yml
package:
  name: axi_nes

sources:
  - files:
      - rtl/axi_lite_pkg.sv
      - rtl/nes_reg_pkg.sv
      - rtl/reg_access_if.sv
      - rtl/hci_cmd_if.sv
      - rtl/axi_lite_slave.sv
      - rtl/nes_reg_bank.sv
      - rtl/hci_port.sv
      - rtl/axi_nes.sv
  - target: test
    files:
      - verif/axi_nes_checker.sv
      - verif/tb_axi_nes.sv

//--- axi_nes.f
rtl/axi_lite_pkg.sv
rtl/nes_reg_pkg.sv
rtl/reg_access_if.sv
rtl/hci_cmd_if.sv
rtl/axi_lite_slave.sv
rtl/nes_reg_bank.sv
rtl/hci_port.sv
rtl/axi_nes.sv
verif/axi_nes_checker.sv
verif/tb_axi_nes.sv

//--- rtl/axi_lite_pkg.sv
//************************************************
// AXI-Lite bus definitions shared by the slave,
// the register access interface and the top level.
// Import where bus widths or response codes are needed.
//************************************************

`default_nettype none

package axi_lite_pkg;

  // Byte address covers 64 words
  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [1:0]            axi_resp_t;

  // Response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- rtl/axi_lite_slave.sv
//************************************************
// AXI-Lite slave front end. Accepts one write or
// read at a time, issues a single register access
// and holds the response until the master takes it.
//************************************************

`timescale 1ns/1ns
`default_nettype none

module axi_lite_slave (
  input  wire                    clk,
  input  wire                    w_axi_rst,

  input  wire                    i_awvalid,
  input  axi_lite_pkg::axi_addr_t i_awaddr,
  output logic                   o_awready,
  input  wire                    i_wvalid,
  input  axi_lite_pkg::axi_data_t i_wdata,
  output logic                   o_wready,
  output logic                   o_bvalid,
  input  wire                    i_bready,
  output axi_lite_pkg::axi_resp_t o_bresp,

  input  wire                    i_arvalid,
  input  axi_lite_pkg::axi_addr_t i_araddr,
  output logic                   o_arready,
  output logic                   o_rvalid,
  input  wire                    i_rready,
  output axi_lite_pkg::axi_resp_t o_rresp,
  output axi_lite_pkg::axi_data_t o_rdata,

  reg_access_if.host             bus
);
  import axi_lite_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WR_ACCESS,
    S_RD_ACCESS,
    S_WAIT_ACK,
    S_WR_RESP,
    S_RD_RESP
  } state_t;

  state_t state;
  logic   is_wr;

  // Request fields, captured once per accepted transaction
  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      if (i_awvalid && i_wvalid) begin
        bus.addr    <= i_awaddr[AXI_ADDR_W-1:2];
        bus.wr_data <= i_wdata;
      end else if (i_arvalid) begin
        bus.addr    <= i_araddr[AXI_ADDR_W-1:2];
        bus.wr_data <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      state      <= S_IDLE;
      is_wr      <= 1'b0;
      o_awready  <= 1'b0;
      o_wready   <= 1'b0;
      o_arready  <= 1'b0;
      o_bvalid   <= 1'b0;
      o_bresp    <= RESP_OKAY;
      o_rvalid   <= 1'b0;
      o_rresp    <= RESP_OKAY;
      o_rdata    <= '0;
      bus.wr_stb <= 1'b0;
      bus.rd_stb <= 1'b0;
    end else begin
      // Single-cycle pulses
      o_awready  <= 1'b0;
      o_wready   <= 1'b0;
      o_arready  <= 1'b0;
      bus.wr_stb <= 1'b0;
      bus.rd_stb <= 1'b0;

      case (state)
        S_IDLE: begin
          // Write wins over a pending read
          if (i_awvalid && i_wvalid) begin
            o_awready <= 1'b1;
            o_wready  <= 1'b1;
            is_wr     <= 1'b1;
            state     <= S_WR_ACCESS;
          end else if (i_arvalid) begin
            o_arready <= 1'b1;
            is_wr     <= 1'b0;
            state     <= S_RD_ACCESS;
          end
        end
        S_WR_ACCESS: begin
          bus.wr_stb <= 1'b1;
          state      <= S_WAIT_ACK;
        end
        S_RD_ACCESS: begin
          bus.rd_stb <= 1'b1;
          state      <= S_WAIT_ACK;
        end
        S_WAIT_ACK: begin
          if (bus.ack) begin
            if (is_wr) begin
              o_bvalid <= 1'b1;
              o_bresp  <= bus.err ? RESP_SLVERR : RESP_OKAY;
              state    <= S_WR_RESP;
            end else begin
              o_rvalid <= 1'b1;
              o_rresp  <= bus.err ? RESP_SLVERR : RESP_OKAY;
              o_rdata  <= bus.rd_data;
              state    <= S_RD_RESP;
            end
          end
        end
        S_WR_RESP: begin
          if (i_bready) begin
            o_bvalid <= 1'b0;
            state    <= S_IDLE;
          end
        end
        S_RD_RESP: begin
          if (i_rready) begin
            o_rvalid <= 1'b0;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/axi_nes.sv
//************************************************
// Top level of the console host control block.
// AXI-Lite slave on one side, console reset,
// joypad and HCI signals on the other.
//************************************************

`timescale 1ns/1ns
`default_nettype none

module axi_nes (
  input  wire                       clk,
  input  wire                       w_axi_rst,

  // AXI-Lite
  input  wire                       i_awvalid,
  input  axi_lite_pkg::axi_addr_t   i_awaddr,
  output logic                      o_awready,
  input  wire                       i_wvalid,
  input  axi_lite_pkg::axi_data_t   i_wdata,
  output logic                      o_wready,
  output logic                      o_bvalid,
  input  wire                       i_bready,
  output axi_lite_pkg::axi_resp_t   o_bresp,
  input  wire                       i_arvalid,
  input  axi_lite_pkg::axi_addr_t   i_araddr,
  output logic                      o_arready,
  output logic                      o_rvalid,
  input  wire                       i_rready,
  output axi_lite_pkg::axi_resp_t   o_rresp,
  output axi_lite_pkg::axi_data_t   o_rdata,

  // Console control
  output logic                      o_console_reset,
  output logic                      o_hci_reset,
  output nes_reg_pkg::joypad_t      o_jp1_state,
  output nes_reg_pkg::joypad_t      o_jp2_state,
  output nes_reg_pkg::hci_addr_t    o_hci_address,
  output nes_reg_pkg::hci_count_t   o_hci_count,

  // HCI
  output nes_reg_pkg::hci_opcode_t  o_hci_opcode,
  output logic                      o_hci_opcode_strobe,
  output nes_reg_pkg::hci_byte_t    o_hci_data,
  output logic                      o_hci_data_strobe,
  output logic                      o_hci_host_ready,
  input  nes_reg_pkg::hci_status_t  i_hci_opcode_status,
  input  wire                       i_hci_opcode_ack,
  input  nes_reg_pkg::hci_byte_t    i_hci_data,
  input  wire                       i_hci_data_strobe,
  input  wire                       i_hci_sm_ready
);

  reg_access_if u_reg_access_if ();
  hci_cmd_if    u_hci_cmd_if ();

  axi_lite_slave u_axi_lite_slave (
    .clk       (clk),
    .w_axi_rst (w_axi_rst),
    .i_awvalid (i_awvalid),
    .i_awaddr  (i_awaddr),
    .o_awready (o_awready),
    .i_wvalid  (i_wvalid),
    .i_wdata   (i_wdata),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .i_araddr  (i_araddr),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rresp   (o_rresp),
    .o_rdata   (o_rdata),
    .bus       (u_reg_access_if.host)
  );

  nes_reg_bank u_nes_reg_bank (
    .clk             (clk),
    .w_axi_rst       (w_axi_rst),
    .bus             (u_reg_access_if.bank),
    .hci             (u_hci_cmd_if.ctrl),
    .o_console_reset (o_console_reset),
    .o_hci_reset     (o_hci_reset),
    .o_jp1_state     (o_jp1_state),
    .o_jp2_state     (o_jp2_state),
    .o_hci_address   (o_hci_address),
    .o_hci_count     (o_hci_count)
  );

  hci_port u_hci_port (
    .clk                 (clk),
    .w_axi_rst           (w_axi_rst),
    .hci                 (u_hci_cmd_if.port),
    .o_hci_opcode        (o_hci_opcode),
    .o_hci_opcode_strobe (o_hci_opcode_strobe),
    .o_hci_data          (o_hci_data),
    .o_hci_data_strobe   (o_hci_data_strobe),
    .o_hci_host_ready    (o_hci_host_ready),
    .i_hci_opcode_status (i_hci_opcode_status),
    .i_hci_opcode_ack    (i_hci_opcode_ack),
    .i_hci_data          (i_hci_data),
    .i_hci_data_strobe   (i_hci_data_strobe),
    .i_hci_sm_ready      (i_hci_sm_ready)
  );

endmodule

`default_nettype wire

//--- rtl/hci_cmd_if.sv
//************************************************
// HCI command path from the register bank (ctrl)
// to the HCI port (port). Strobes last one cycle,
// status and returned data are levels.
//************************************************

`timescale 1ns/1ns
`default_nettype none

interface hci_cmd_if;
  import nes_reg_pkg::*;

  hci_opcode_t opcode;
  logic        opcode_stb;
  hci_byte_t   din;
  logic        din_stb;
  logic        host_ready_stb;

  // Captured from the core
  hci_status_t status;
  hci_byte_t   dout;
  logic        sm_ready;

  modport ctrl (output opcode, opcode_stb, din, din_stb, host_ready_stb,
                input status, dout, sm_ready);
  modport port (input opcode, opcode_stb, din, din_stb, host_ready_stb,
                output status, dout, sm_ready);

endinterface

`default_nettype wire

//--- rtl/hci_port.sv
//************************************************
// Output stage toward the console HCI. Registers
// command strobes and values, captures the status
// and returned data byte coming back from the core.
//************************************************

`timescale 1ns/1ns
`default_nettype none

module hci_port (
  input  wire                       clk,
  input  wire                       w_axi_rst,

  hci_cmd_if.port                   hci,

  output nes_reg_pkg::hci_opcode_t  o_hci_opcode,
  output logic                      o_hci_opcode_strobe,
  output nes_reg_pkg::hci_byte_t    o_hci_data,
  output logic                      o_hci_data_strobe,
  output logic                      o_hci_host_ready,

  input  nes_reg_pkg::hci_status_t  i_hci_opcode_status,
  input  wire                       i_hci_opcode_ack,
  input  nes_reg_pkg::hci_byte_t    i_hci_data,
  input  wire                       i_hci_data_strobe,
  input  wire                       i_hci_sm_ready
);
  import nes_reg_pkg::*;

  hci_status_t status_q;
  hci_byte_t   dout_q;

  // Commands toward the core
  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      o_hci_opcode        <= '0;
      o_hci_opcode_strobe <= 1'b0;
      o_hci_data          <= '0;
      o_hci_data_strobe   <= 1'b0;
      o_hci_host_ready    <= 1'b0;
    end else begin
      o_hci_opcode_strobe <= hci.opcode_stb;
      o_hci_data_strobe   <= hci.din_stb;
      o_hci_host_ready    <= hci.host_ready_stb;
      if (hci.opcode_stb) begin
        o_hci_opcode <= hci.opcode;
      end
      if (hci.din_stb) begin
        o_hci_data <= hci.din;
      end
    end
  end

  // Status on opcode ack, byte on data strobe
  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      status_q <= '0;
      dout_q   <= '0;
    end else begin
      if (i_hci_opcode_ack) begin
        status_q <= i_hci_opcode_status;
      end
      if (i_hci_data_strobe) begin
        dout_q <= i_hci_data;
      end
    end
  end

  assign hci.status   = status_q;
  assign hci.dout     = dout_q;
  assign hci.sm_ready = i_hci_sm_ready;

endmodule

`default_nettype wire

//--- rtl/nes_reg_bank.sv
//************************************************
// Register bank of the console host block. Decodes
// word accesses, holds the control registers and
// raises HCI command strobes toward the HCI port.
//************************************************

`timescale 1ns/1ns
`default_nettype none

module nes_reg_bank (
  input  wire                      clk,
  input  wire                      w_axi_rst,

  reg_access_if.bank               bus,
  hci_cmd_if.ctrl                  hci,

  output logic                     o_console_reset,
  output logic                     o_hci_reset,
  output nes_reg_pkg::joypad_t     o_jp1_state,
  output nes_reg_pkg::joypad_t     o_jp2_state,
  output nes_reg_pkg::hci_addr_t   o_hci_address,
  output nes_reg_pkg::hci_count_t  o_hci_count
);
  import axi_lite_pkg::*;
  import nes_reg_pkg::*;

  logic      addr_valid;
  logic      access;
  axi_data_t rd_mux;

  assign addr_valid = (bus.addr <= REG_LAST);
  assign access     = bus.wr_stb || bus.rd_stb;

  // Read data for the current index
  always_comb begin
    rd_mux = '0;
    case (bus.addr)
      REG_CONTROL: begin
        rd_mux[CTRL_HCI_RESET_BIT]     = o_hci_reset;
        rd_mux[CTRL_CONSOLE_RESET_BIT] = o_console_reset;
      end
      REG_STATUS: begin
        rd_mux[STATUS_HCI_READY_BIT]        = hci.sm_ready;
        rd_mux[STATUS_HCI_STATUS_LSB +: 16] = hci.status;
      end
      REG_HCI_COUNT:  rd_mux = o_hci_count;
      REG_HCI_ADDR:   rd_mux = {16'h0000, o_hci_address};
      REG_HCI_OPCODE: rd_mux = {24'h000000, hci.opcode};
      REG_HCI_DATA:   rd_mux = {24'h000000, hci.dout};
      // Image geometry has no source without the video path
      REG_IMAGE_WIDTH, REG_IMAGE_HEIGHT, REG_IMAGE_SIZE: rd_mux = '0;
      REG_VERSION:    rd_mux = VERSION_WORD;
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      // Console and HCI come up held in reset
      o_console_reset    <= 1'b1;
      o_hci_reset        <= 1'b1;
      o_jp1_state        <= '0;
      o_jp2_state        <= '0;
      o_hci_address      <= '0;
      o_hci_count        <= '0;
      hci.opcode         <= '0;
      hci.din            <= '0;
      hci.opcode_stb     <= 1'b0;
      hci.din_stb        <= 1'b0;
      hci.host_ready_stb <= 1'b0;
      bus.ack            <= 1'b0;
      bus.err            <= 1'b0;
      bus.rd_data        <= '0;
    end else begin
      hci.opcode_stb     <= 1'b0;
      hci.din_stb        <= 1'b0;
      hci.host_ready_stb <= 1'b0;

      // Every access is answered the next cycle
      bus.ack     <= access;
      bus.err     <= access && !addr_valid;
      bus.rd_data <= (bus.rd_stb && addr_valid) ? rd_mux : '0;

      if (bus.wr_stb && addr_valid) begin
        case (bus.addr)
          REG_CONTROL: begin
            o_hci_reset     <= bus.wr_data[CTRL_HCI_RESET_BIT];
            o_console_reset <= bus.wr_data[CTRL_CONSOLE_RESET_BIT];
          end
          REG_USER_INPUT: begin
            o_jp1_state <= bus.wr_data[7:0];
            o_jp2_state <= bus.wr_data[15:8];
          end
          REG_HCI_COUNT: o_hci_count   <= bus.wr_data;
          REG_HCI_ADDR:  o_hci_address <= bus.wr_data[15:0];
          REG_HCI_OPCODE: begin
            hci.opcode     <= bus.wr_data[7:0];
            hci.opcode_stb <= 1'b1;
          end
          REG_HCI_DATA: begin
            hci.din     <= bus.wr_data[7:0];
            hci.din_stb <= 1'b1;
          end
          // Host ready only on bit 0 set
          REG_HCI_READ_STB: hci.host_ready_stb <= bus.wr_data[0];
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/nes_reg_pkg.sv
//************************************************
// Register map and console-side types of the host
// control block. Used by the register bank, the HCI
// port, both interfaces and the top level.
//************************************************

`default_nettype none

package nes_reg_pkg;

  // Word index, byte address bits 7:2
  typedef logic [5:0] reg_index_t;

  localparam reg_index_t REG_CONTROL      = 6'd0;
  localparam reg_index_t REG_STATUS       = 6'd1;
  localparam reg_index_t REG_USER_INPUT   = 6'd2;
  localparam reg_index_t REG_HCI_COUNT    = 6'd3;
  localparam reg_index_t REG_HCI_ADDR     = 6'd4;
  localparam reg_index_t REG_HCI_OPCODE   = 6'd5;
  localparam reg_index_t REG_HCI_DATA     = 6'd6;
  localparam reg_index_t REG_HCI_READ_STB = 6'd7;
  localparam reg_index_t REG_IMAGE_WIDTH  = 6'd8;
  localparam reg_index_t REG_IMAGE_HEIGHT = 6'd9;
  localparam reg_index_t REG_IMAGE_SIZE   = 6'd10;
  localparam reg_index_t REG_VERSION      = 6'd11;

  // Highest index that decodes
  localparam reg_index_t REG_LAST = REG_VERSION;

  // Control word bits
  localparam int CTRL_HCI_RESET_BIT     = 0;
  localparam int CTRL_CONSOLE_RESET_BIT = 1;

  // Status word bits
  localparam int STATUS_HCI_READY_BIT  = 1;
  localparam int STATUS_HCI_STATUS_LSB = 16;

  // Version fields
  localparam logic [3:0] VERSION_MAJOR    = 4'd1;
  localparam logic [7:0] VERSION_MINOR    = 8'd0;
  localparam logic [3:0] VERSION_REVISION = 4'd0;

  localparam logic [31:0] VERSION_WORD = {
    VERSION_MAJOR, VERSION_MINOR, VERSION_REVISION, 16'h0000
  };

  // Console side
  typedef logic [7:0]  joypad_t;
  typedef logic [7:0]  hci_opcode_t;
  typedef logic [7:0]  hci_byte_t;
  typedef logic [15:0] hci_addr_t;
  typedef logic [31:0] hci_count_t;
  typedef logic [15:0] hci_status_t;

endpackage

`default_nettype wire

//--- rtl/reg_access_if.sv
//************************************************
// Single-access register port between the bus
// slave (host) and the register bank (bank).
// One strobe per access, ack one cycle later.
//************************************************

`timescale 1ns/1ns
`default_nettype none

interface reg_access_if;
  import axi_lite_pkg::*;
  import nes_reg_pkg::*;

  reg_index_t addr;
  logic       wr_stb;
  axi_data_t  wr_data;
  logic       rd_stb;

  // Valid in the ack cycle
  logic       ack;
  logic       err;
  axi_data_t  rd_data;

  modport host (output addr, wr_stb, wr_data, rd_stb, input ack, err, rd_data);
  modport bank (input addr, wr_stb, wr_data, rd_stb, output ack, err, rd_data);

endinterface

`default_nettype wire

//--- verif/axi_nes_checker.sv
//**************************************************
// Checker for the console host control block.
// Watches the DUT ports, counts command strobes and
// compares responses when the testbench asks for it.
//**************************************************

`timescale 1ns/1ns
`default_nettype none

module axi_nes_checker (
  input wire                      clk,
  input wire                      i_awready,
  input wire                      i_wready,
  input wire                      i_arready,
  input wire                      i_bvalid,
  input wire                      i_bready,
  input axi_lite_pkg::axi_resp_t  i_bresp,
  input wire                      i_rvalid,
  input wire                      i_rready,
  input axi_lite_pkg::axi_resp_t  i_rresp,
  input axi_lite_pkg::axi_data_t  i_rdata,
  input wire                      i_opcode_strobe,
  input nes_reg_pkg::hci_opcode_t i_opcode,
  input wire                      i_data_strobe,
  input nes_reg_pkg::hci_byte_t   i_data,
  input wire                      i_host_ready,
  input wire [65:0]               i_pins
);
  import axi_lite_pkg::*;
  import nes_reg_pkg::*;

  int          value_errors    = 0;
  int          protocol_errors = 0;
  int          opcode_pulses   = 0;
  int          data_pulses     = 0;
  int          ready_pulses    = 0;
  hci_opcode_t last_opcode;
  hci_byte_t   last_data;
  axi_resp_t   last_resp;
  axi_data_t   last_rdata;
  logic        pending = 1'b0;
  logic        b_stall = 1'b0;
  logic        r_stall = 1'b0;
  axi_resp_t   held_bresp;
  axi_resp_t   held_rresp;
  axi_data_t   held_rdata;

  task automatic compare_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // Pins as {console_reset, hci_reset, jp2, jp1, hci_address, hci_count}
  task automatic compare_pins(input string name, input logic [65:0] exp_pins);
    compare_value(name, "reset and joypad pins", exp_pins[65:48], i_pins[65:48]);
    compare_value(name, "hci address", exp_pins[47:32], i_pins[47:32]);
    compare_value(name, "hci count", exp_pins[31:0], i_pins[31:0]);
  endtask

  task automatic check_pulse(input string name, input string what, input bit want,
                             input int count);
    if (want && count == 0) begin
      protocol_errors++;
      $display("%s: the expected %s pulse never appeared", name, what);
    end else if (count != (want ? 1 : 0)) begin
      value_errors++;
      $display("FAILED %s %s pulses: expected %0d, actual %0d", name, what,
               want ? 1 : 0, count);
    end
  endtask

  task automatic start_entry();
    opcode_pulses = 0;
    data_pulses   = 0;
    ready_pulses  = 0;
    last_resp     = 'x;
    last_rdata    = 'x;
  endtask

  task automatic check_idle(input string name, input logic [65:0] exp_pins);
    compare_value(name, "ready, valid and strobe outputs", '0,
                  {i_awready, i_wready, i_arready, i_bvalid, i_rvalid,
                   i_opcode_strobe, i_data_strobe, i_host_ready});
    compare_pins(name, exp_pins);
  endtask

  // Strobe column is one-hot {host_ready, data, opcode}
  task automatic check_entry(input string name, input bit is_wr, input axi_resp_t exp_resp,
                             input axi_data_t exp_rdata, input logic [2:0] stb,
                             input logic [7:0] stb_val, input logic [65:0] exp_pins);
    compare_value(name, "response", exp_resp, last_resp);
    if (!is_wr) begin
      compare_value(name, "read data", exp_rdata, last_rdata);
    end
    check_pulse(name, "opcode strobe", stb[0], opcode_pulses);
    check_pulse(name, "data strobe", stb[1], data_pulses);
    check_pulse(name, "host ready", stb[2], ready_pulses);
    if (stb[0] && opcode_pulses > 0) begin
      compare_value(name, "opcode", stb_val, last_opcode);
    end
    if (stb[1] && data_pulses > 0) begin
      compare_value(name, "data byte", stb_val, last_data);
    end
    compare_pins(name, exp_pins);
  endtask

  always @(posedge clk) begin
    // Response must hold while the master stalls
    if (b_stall && (i_bvalid !== 1'b1 || i_bresp !== held_bresp)) begin
      protocol_errors++;
      $display("Protocol error at %0t ns: write response dropped or changed while bready was low",
               $time);
    end
    if (r_stall && (i_rvalid !== 1'b1 || i_rresp !== held_rresp || i_rdata !== held_rdata)) begin
      protocol_errors++;
      $display("Protocol error at %0t ns: read response dropped or changed while rready was low",
               $time);
    end
    if (pending && (i_awready || i_wready || i_arready)) begin
      protocol_errors++;
      $display("Protocol error at %0t ns: new request accepted before the response was taken",
               $time);
    end
    if (i_awready !== i_wready) begin
      protocol_errors++;
      $display("Protocol error at %0t ns: awready and wready did not pulse together",
               $time);
    end
    b_stall    = i_bvalid && !i_bready;
    r_stall    = i_rvalid && !i_rready;
    held_bresp = i_bresp;
    held_rresp = i_rresp;
    held_rdata = i_rdata;
    if (i_awready || i_arready) begin
      pending = 1'b1;
    end
    if (i_bvalid && i_bready) begin
      last_resp = i_bresp;
      pending   = 1'b0;
    end
    if (i_rvalid && i_rready) begin
      last_resp  = i_rresp;
      last_rdata = i_rdata;
      pending    = 1'b0;
    end
    // Strobes toward the core
    if (i_opcode_strobe) begin
      opcode_pulses++;
      last_opcode = i_opcode;
    end
    if (i_data_strobe) begin
      data_pulses++;
      last_data = i_data;
    end
    if (i_host_ready) begin
      ready_pulses++;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_axi_nes.sv
//**************************************************
// Testbench for the console host control block.
// Applies a table of AXI-Lite transactions, models
// the HCI side of the console core and reports the
// error counts at the end of the run.
//**************************************************

`timescale 1ns/1ns
`default_nettype none

module tb_axi_nes;
  import axi_lite_pkg::*;
  import nes_reg_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 5;
  localparam int NUM_TESTS      = 21;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 50;
  localparam logic [31:0] LCG_SEED = 32'h8a72_c771;

  // Pin sets as {console_reset, hci_reset, jp2, jp1, hci_address, hci_count}
  localparam logic [65:0] PINS_RESET = {2'b11, 16'h0000, 16'h0000, 32'h0000_0000};
  localparam logic [65:0] PINS_COUNT = {2'b11, 16'h0000, 16'h0000, 32'hDEAD_BEEF};
  localparam logic [65:0] PINS_ADDR  = {2'b11, 16'h0000, 16'hABCD, 32'hDEAD_BEEF};
  localparam logic [65:0] PINS_JOY   = {2'b11, 8'h5A, 8'hC3, 16'hABCD, 32'hDEAD_BEEF};
  localparam logic [65:0] PINS_RUN   = {2'b00, 8'h5A, 8'hC3, 16'hABCD, 32'hDEAD_BEEF};

  logic        clk;
  logic        w_axi_rst;
  logic        i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
  axi_addr_t   i_awaddr, i_araddr;
  axi_data_t   i_wdata;
  logic        o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
  axi_resp_t   o_bresp, o_rresp;
  axi_data_t   o_rdata;
  logic        o_console_reset, o_hci_reset;
  joypad_t     o_jp1_state, o_jp2_state;
  hci_addr_t   o_hci_address;
  hci_count_t  o_hci_count;
  hci_opcode_t o_hci_opcode;
  hci_byte_t   o_hci_data;
  logic        o_hci_opcode_strobe, o_hci_data_strobe, o_hci_host_ready;
  hci_status_t i_hci_opcode_status;
  hci_byte_t   i_hci_data;
  logic        i_hci_opcode_ack, i_hci_data_strobe, i_hci_sm_ready;

  // Stimulus table
  // Strobe column is one-hot {host_ready, data, opcode}
  string       t_name    [NUM_TESTS];
  bit          t_is_wr   [NUM_TESTS];
  axi_addr_t   t_addr    [NUM_TESTS];
  axi_data_t   t_data    [NUM_TESTS];
  axi_resp_t   t_resp    [NUM_TESTS];
  axi_data_t   t_rdata   [NUM_TESTS];
  logic [2:0]  t_stb     [NUM_TESTS];
  logic [7:0]  t_stb_val [NUM_TESTS];
  int          t_hold    [NUM_TESTS];
  logic [65:0] t_pins    [NUM_TESTS];
  int          n_entries = 0;

  axi_nes u_axi_nes (.*);

  axi_nes_checker u_checker (
    .clk             (clk),
    .i_awready       (o_awready),
    .i_wready        (o_wready),
    .i_arready       (o_arready),
    .i_bvalid        (o_bvalid),
    .i_bready        (i_bready),
    .i_bresp         (o_bresp),
    .i_rvalid        (o_rvalid),
    .i_rready        (i_rready),
    .i_rresp         (o_rresp),
    .i_rdata         (o_rdata),
    .i_opcode_strobe (o_hci_opcode_strobe),
    .i_opcode        (o_hci_opcode),
    .i_data_strobe   (o_hci_data_strobe),
    .i_data          (o_hci_data),
    .i_host_ready    (o_hci_host_ready),
    .i_pins          ({o_console_reset, o_hci_reset, o_jp2_state, o_jp1_state,
                       o_hci_address, o_hci_count})
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Status the core model reports for an opcode
  function automatic hci_status_t status_of(input hci_opcode_t op);
    logic [31:0] r;
    r = lcg_next(LCG_SEED ^ {24'h0, op});
    return r[31:16];
  endfunction

  // Byte the core model returns after host ready
  function automatic hci_byte_t reply_of(input hci_byte_t b);
    logic [31:0] r;
    r = lcg_next(lcg_next(LCG_SEED ^ {24'h0, b}));
    return r[23:16];
  endfunction

  task automatic add_entry(input string name, input bit is_wr, input axi_addr_t addr,
                           input axi_data_t data, input axi_resp_t resp,
                           input axi_data_t rdata, input logic [2:0] stb,
                           input logic [7:0] stb_val, input int hold,
                           input logic [65:0] pins);
    t_name[n_entries]    = name;
    t_is_wr[n_entries]   = is_wr;
    t_addr[n_entries]    = addr;
    t_data[n_entries]    = data;
    t_resp[n_entries]    = resp;
    t_rdata[n_entries]   = rdata;
    t_stb[n_entries]     = stb;
    t_stb_val[n_entries] = stb_val;
    t_hold[n_entries]    = hold;
    t_pins[n_entries]    = pins;
    n_entries++;
  endtask

  task automatic build_table();
    axi_data_t status_word;
    axi_data_t reply_word;
    // sm_ready is set by the model together with the ack
    status_word = {status_of(8'hA5), 16'h0002};
    reply_word  = {24'h0, reply_of(8'h3C)};
    add_entry("reset_control", 0, 8'h00, '0, RESP_OKAY, 32'h3, 3'b000, '0, 0, PINS_RESET);
    add_entry("count_write", 1, 8'h0C, 32'hDEAD_BEEF, RESP_OKAY, '0, 3'b000, '0, 2, PINS_COUNT);
    add_entry("count_read", 0, 8'h0C, '0, RESP_OKAY, 32'hDEAD_BEEF, 3'b000, '0, 3, PINS_COUNT);
    add_entry("addr_write", 1, 8'h10, 32'h1234_ABCD, RESP_OKAY, '0, 3'b000, '0, 0, PINS_ADDR);
    add_entry("addr_read", 0, 8'h10, '0, RESP_OKAY, 32'h0000_ABCD, 3'b000, '0, 1, PINS_ADDR);
    add_entry("joypad_write", 1, 8'h08, 32'h0000_5AC3, RESP_OKAY, '0, 3'b000, '0, 0, PINS_JOY);
    add_entry("control_write", 1, 8'h00, '0, RESP_OKAY, '0, 3'b000, '0, 0, PINS_RUN);
    add_entry("control_read", 0, 8'h00, '0, RESP_OKAY, '0, 3'b000, '0, 0, PINS_RUN);
    add_entry("opcode_write", 1, 8'h14, 32'h0000_01A5, RESP_OKAY, '0, 3'b001, 8'hA5, 1, PINS_RUN);
    add_entry("status_read", 0, 8'h04, '0, RESP_OKAY, status_word, 3'b000, '0, 0, PINS_RUN);
    add_entry("opcode_read", 0, 8'h14, '0, RESP_OKAY, 32'h0000_00A5, 3'b000, '0, 0, PINS_RUN);
    add_entry("data_write", 1, 8'h18, 32'h0000_FF3C, RESP_OKAY, '0, 3'b010, 8'h3C, 0, PINS_RUN);
    add_entry("ready_clear", 1, 8'h1C, 32'h2, RESP_OKAY, '0, 3'b000, '0, 0, PINS_RUN);
    add_entry("ready_set", 1, 8'h1C, 32'h1, RESP_OKAY, '0, 3'b100, '0, 2, PINS_RUN);
    add_entry("data_read", 0, 8'h18, '0, RESP_OKAY, reply_word, 3'b000, '0, 0, PINS_RUN);
    add_entry("version_read", 0, 8'h2C, '0, RESP_OKAY, 32'h1000_0000, 3'b000, '0, 4, PINS_RUN);
    add_entry("image_read", 0, 8'h20, '0, RESP_OKAY, '0, 3'b000, '0, 0, PINS_RUN);
    add_entry("bad_read", 0, 8'h30, '0, RESP_SLVERR, '0, 3'b000, '0, 2, PINS_RUN);
    // Index 35 shares its low bits with the count register
    add_entry("bad_write", 1, 8'h8C, 32'hFFFF_FFFF, RESP_SLVERR, '0, 3'b000, '0, 1, PINS_RUN);
    add_entry("count_after_bad", 0, 8'h0C, '0, RESP_OKAY, 32'hDEAD_BEEF, 3'b000, '0, 0, PINS_RUN);
    add_entry("addr_after_bad", 0, 8'h10, '0, RESP_OKAY, 32'h0000_ABCD, 3'b000, '0, 0, PINS_RUN);
  endtask

  // Runs one bus transaction and hands the result to the checker
  task automatic run_entry(input int i);
    u_checker.start_entry();
    if (t_is_wr[i]) begin
      i_awvalid = 1'b1;
      i_awaddr  = t_addr[i];
      i_wvalid  = 1'b1;
      i_wdata   = t_data[i];
    end else begin
      i_arvalid = 1'b1;
      i_araddr  = t_addr[i];
    end
    do begin
      @(posedge clk);
      #1;
    end while (!(t_is_wr[i] ? o_awready : o_arready));
    // A read stays pending until the response is taken
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    i_arvalid = 1'b1;
    while (!(o_bvalid || o_rvalid)) begin
      @(posedge clk);
      #1;
    end
    repeat (t_hold[i]) begin
      @(posedge clk);
      #1;
    end
    i_arvalid = 1'b0;
    i_bready  = t_is_wr[i];
    i_rready  = !t_is_wr[i];
    @(posedge clk);
    #1;
    i_bready = 1'b0;
    i_rready = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    u_checker.check_entry(t_name[i], t_is_wr[i], t_resp[i], t_rdata[i], t_stb[i],
                          t_stb_val[i], t_pins[i]);
  endtask

  task automatic report_counts();
    $display("Errors: %0d value, %0d protocol", u_checker.value_errors,
             u_checker.protocol_errors);
  endtask

  // Core model answers strobes one cycle later
  always @(posedge clk) begin
    #1;
    i_hci_opcode_ack  = o_hci_opcode_strobe;
    i_hci_data_strobe = o_hci_host_ready;
    if (o_hci_opcode_strobe) begin
      i_hci_opcode_status = status_of(o_hci_opcode);
      i_hci_sm_ready      = 1'b1;
    end
    if (o_hci_host_ready) begin
      i_hci_data = reply_of(o_hci_data);
    end
  end

  initial begin
    int i;
    clk                 = 1'b0;
    w_axi_rst           = 1'b1;
    i_awvalid           = 1'b0;
    i_awaddr            = '0;
    i_wvalid            = 1'b0;
    i_wdata             = '0;
    i_bready            = 1'b0;
    i_arvalid           = 1'b0;
    i_araddr            = '0;
    i_rready            = 1'b0;
    i_hci_opcode_status = '0;
    i_hci_opcode_ack    = 1'b0;
    i_hci_data          = '0;
    i_hci_data_strobe   = 1'b0;
    i_hci_sm_ready      = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    u_checker.check_idle("reset_outputs", PINS_RESET);
    w_axi_rst = 1'b0;
    for (i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    report_counts();
    if (u_checker.value_errors + u_checker.protocol_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + TIMEOUT_CYCLES));
    $display("Watchdog expired after %0d cycles, a transaction never completed",
             RESET_CYCLES + TIMEOUT_CYCLES);
    report_counts();
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
